// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // one sram chip holds 1M words, address bits 21..2
    localparam int SRAM_ADDR_W = 20;

    // address map
    localparam logic [3:0]  RAM_BASE     = 4'h8;      // 0x8xxx_xxxx
    localparam int          RAM_CHIP_BIT = 22;        // set selects the ext chip
    localparam logic [15:0] PERIPH_BASE  = 16'hBFD0;  // 0xBFD0_xxxx

    // register banks in the peripheral region
    localparam int NUM_PERIPH  = 4;
    localparam int SLOT_W      = 2;
    localparam int SLOT_LSB    = 8;  // slot from bits 9..8
    localparam int REG_IDX_W   = 2;
    localparam int REG_IDX_LSB = 2;  // register from bits 3..2

    // ram access timing
    localparam int RAM_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_W      = $clog2(RAM_WAIT_CYCLES + 1);

    // target of a read, passed from the decoder to the read mux
    localparam int         KIND_W    = 2;
    localparam logic [1:0] RD_NONE   = 2'd0;
    localparam logic [1:0] RD_PERIPH = 2'd1;
    localparam logic [1:0] RD_RAM    = 2'd2;

endpackage

// File: hdl/dbus_decoder.sv
`timescale 1ns/1ps

module dbus_decoder (
    input  logic [soc_bus_pkg::ADDR_W-1:0]      m_addr_i,
    input  logic [soc_bus_pkg::BE_W-1:0]        m_be_i,
    input  logic                                m_read_i,
    input  logic                                m_write_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]      m_wrdata_i,

    // register banks
    output logic [soc_bus_pkg::NUM_PERIPH-1:0]  bank_we_o,
    output logic [soc_bus_pkg::REG_IDX_W-1:0]   reg_idx_o,
    output logic [soc_bus_pkg::DATA_W-1:0]      wr_data_o,
    output logic [soc_bus_pkg::BE_W-1:0]        wr_be_o,

    // sram controller, chip bit on top of the word address
    output logic                                ram_req_o,
    output logic                                ram_write_o,
    output logic [soc_bus_pkg::SRAM_ADDR_W:0]   ram_addr_o,

    // read target for the read mux
    output logic [soc_bus_pkg::KIND_W-1:0]      rd_kind_o,
    output logic [soc_bus_pkg::SLOT_W-1:0]      rd_slot_o
);

    logic                           ram_hit;
    logic                           periph_hit;
    logic [soc_bus_pkg::SLOT_W-1:0] slot;

    assign ram_hit    = (m_addr_i[soc_bus_pkg::ADDR_W-1 -: 4] == soc_bus_pkg::RAM_BASE);
    assign periph_hit = (m_addr_i[soc_bus_pkg::ADDR_W-1 -: 16] == soc_bus_pkg::PERIPH_BASE);

    assign slot      = m_addr_i[soc_bus_pkg::SLOT_LSB +: soc_bus_pkg::SLOT_W];
    assign reg_idx_o = m_addr_i[soc_bus_pkg::REG_IDX_LSB +: soc_bus_pkg::REG_IDX_W];

    // data and byte enables are shared by banks and ram
    assign wr_data_o = m_wrdata_i;
    assign wr_be_o   = m_be_i;

    // one-hot bank write strobe, unmapped writes hit nothing
    always_comb begin
        bank_we_o = '0;
        if (periph_hit && m_write_i) begin
            bank_we_o[slot] = 1'b1;
        end
    end

    assign ram_req_o   = ram_hit && (m_read_i || m_write_i);
    assign ram_write_o = m_write_i;
    assign ram_addr_o  = {m_addr_i[soc_bus_pkg::RAM_CHIP_BIT],
                          m_addr_i[2 +: soc_bus_pkg::SRAM_ADDR_W]};

    always_comb begin
        rd_kind_o = soc_bus_pkg::RD_NONE;
        if (m_read_i) begin
            if (ram_hit) begin
                rd_kind_o = soc_bus_pkg::RD_RAM;
            end else if (periph_hit) begin
                rd_kind_o = soc_bus_pkg::RD_PERIPH;
            end
        end
    end

    assign rd_slot_o = slot;

endmodule

// File: hdl/reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               we_i,
    input  logic [soc_bus_pkg::REG_IDX_W-1:0]  reg_idx_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     wr_data_i,
    input  logic [soc_bus_pkg::BE_W-1:0]       wr_be_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     pins_i,
    output logic [soc_bus_pkg::DATA_W-1:0]     rd_data_o,
    output logic [soc_bus_pkg::DATA_W-1:0]     port_o
);

    logic [soc_bus_pkg::DATA_W-1:0] reg0_q;  // output port
    logic [soc_bus_pkg::DATA_W-1:0] reg2_q;
    logic [soc_bus_pkg::DATA_W-1:0] reg3_q;

    function automatic logic [soc_bus_pkg::DATA_W-1:0] merge_bytes(
        input logic [soc_bus_pkg::DATA_W-1:0] old_word,
        input logic [soc_bus_pkg::DATA_W-1:0] new_word,
        input logic [soc_bus_pkg::BE_W-1:0]   be
    );
        logic [soc_bus_pkg::DATA_W-1:0] res;
        res = old_word;
        for (int b = 0; b < soc_bus_pkg::BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg0_q <= '0;
            reg2_q <= '0;
            reg3_q <= '0;
        end else if (we_i) begin
            case (reg_idx_i)
                2'd0:    reg0_q <= merge_bytes(reg0_q, wr_data_i, wr_be_i);
                2'd2:    reg2_q <= merge_bytes(reg2_q, wr_data_i, wr_be_i);
                2'd3:    reg3_q <= merge_bytes(reg3_q, wr_data_i, wr_be_i);
                default: ;  // register 1 is the input pins
            endcase
        end
    end

    // read word lands one cycle after the index
    always_ff @(posedge clk) begin
        case (reg_idx_i)
            2'd0:    rd_data_o <= reg0_q;
            2'd1:    rd_data_o <= pins_i;
            2'd2:    rd_data_o <= reg2_q;
            default: rd_data_o <= reg3_q;
        endcase
    end

    assign port_o = reg0_q;

endmodule

// File: hdl/dbus_rdmux.sv
`timescale 1ns/1ps

module dbus_rdmux (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [soc_bus_pkg::KIND_W-1:0]     rd_kind_i,
    input  logic [soc_bus_pkg::SLOT_W-1:0]     rd_slot_i,
    input  logic [soc_bus_pkg::NUM_PERIPH-1:0][soc_bus_pkg::DATA_W-1:0] bank_rd_data_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     ram_rd_data_i,
    input  logic                               ram_done_i,
    output logic [soc_bus_pkg::DATA_W-1:0]     m_rddata_o
);

    logic [soc_bus_pkg::KIND_W-1:0] kind_q;
    logic [soc_bus_pkg::SLOT_W-1:0] slot_q;

    // follow the banks' registered read port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q <= soc_bus_pkg::RD_NONE;
            slot_q <= '0;
        end else begin
            kind_q <= rd_kind_i;
            slot_q <= rd_slot_i;
        end
    end

    always_comb begin
        if (ram_done_i) begin
            m_rddata_o = ram_rd_data_i;  // ram word bypasses the stage
        end else if (kind_q == soc_bus_pkg::RD_PERIPH) begin
            m_rddata_o = bank_rd_data_i[slot_q];
        end else begin
            m_rddata_o = '0;  // unmapped reads
        end
    end

endmodule

// File: hdl/sram_ctrl.sv
`timescale 1ns/1ps

module sram_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_i,
    input  logic                                 write_i,
    input  logic [soc_bus_pkg::SRAM_ADDR_W:0]    addr_i,  // chip bit on top
    input  logic [soc_bus_pkg::BE_W-1:0]         be_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]       wr_data_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]       base_ram_data_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]       ext_ram_data_i,

    output logic                                 stall_o,
    output logic                                 done_o,
    output logic [soc_bus_pkg::DATA_W-1:0]       rd_data_o,

    output logic [soc_bus_pkg::SRAM_ADDR_W-1:0]  ram_addr_o,
    output logic [soc_bus_pkg::BE_W-1:0]         ram_be_n_o,
    output logic                                 base_ram_ce_n_o,
    output logic                                 ext_ram_ce_n_o,
    output logic                                 ram_oe_n_o,
    output logic                                 ram_we_n_o,
    output logic [soc_bus_pkg::DATA_W-1:0]       ram_data_o,
    output logic                                 ram_data_oe_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE
    } state_t;

    state_t                               state_q;
    logic [soc_bus_pkg::WAIT_CNT_W-1:0]   wait_cnt_q;

    logic [soc_bus_pkg::SRAM_ADDR_W:0]    addr_q;
    logic [soc_bus_pkg::BE_W-1:0]         be_q;
    logic [soc_bus_pkg::DATA_W-1:0]       data_q;
    logic                                 write_q;

    logic                                 start;
    logic                                 active;
    logic                                 is_write;
    logic                                 chip_ext;
    logic [soc_bus_pkg::SRAM_ADDR_W:0]    addr_sel;
    logic [soc_bus_pkg::BE_W-1:0]         be_sel;
    logic [soc_bus_pkg::DATA_W-1:0]       data_sel;

    assign start  = (state_q == ST_IDLE) && req_i;
    assign active = start || (state_q == ST_ACCESS);

    // first strobe cycle runs straight from the request, then from the latches
    assign addr_sel = (state_q == ST_IDLE) ? addr_i    : addr_q;
    assign be_sel   = (state_q == ST_IDLE) ? be_i      : be_q;
    assign data_sel = (state_q == ST_IDLE) ? wr_data_i : data_q;
    assign is_write = (state_q == ST_IDLE) ? write_i   : write_q;
    assign chip_ext = addr_sel[soc_bus_pkg::SRAM_ADDR_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q    <= ST_ACCESS;
                        wait_cnt_q <= 1;  // this cycle already counts
                    end
                end
                ST_ACCESS: begin
                    if (wait_cnt_q == soc_bus_pkg::WAIT_CNT_W'(soc_bus_pkg::RAM_WAIT_CYCLES - 1)) begin
                        state_q <= ST_DONE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;  // done, held request ignored
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr_i;
            be_q    <= be_i;
            data_q  <= wr_data_i;
            write_q <= write_i;
        end
    end

    // sample the chip at the end of the last strobe cycle
    always_ff @(posedge clk) begin
        if (state_q == ST_ACCESS) begin
            rd_data_o <= addr_q[soc_bus_pkg::SRAM_ADDR_W] ? ext_ram_data_i : base_ram_data_i;
        end
    end

    assign stall_o = active;
    assign done_o  = (state_q == ST_DONE);

    assign ram_addr_o      = addr_sel[soc_bus_pkg::SRAM_ADDR_W-1:0];
    assign ram_be_n_o      = ~be_sel;
    assign base_ram_ce_n_o = ~(active && !chip_ext);
    assign ext_ram_ce_n_o  = ~(active && chip_ext);
    assign ram_oe_n_o      = ~(active && !is_write);
    assign ram_we_n_o      = ~(active && is_write);
    assign ram_data_o      = data_sel;
    assign ram_data_oe_o   = active && is_write;

endmodule

// File: hdl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // data bus master
    input  logic [soc_bus_pkg::ADDR_W-1:0]       m_addr_i,
    input  logic [soc_bus_pkg::BE_W-1:0]         m_be_i,
    input  logic                                 m_read_i,
    input  logic                                 m_write_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]       m_wrdata_i,
    output logic [soc_bus_pkg::DATA_W-1:0]       m_rddata_o,
    output logic                                 m_stall_o,

    input  logic [soc_bus_pkg::NUM_PERIPH-1:0][soc_bus_pkg::DATA_W-1:0] periph_in_i,
    output logic [soc_bus_pkg::NUM_PERIPH-1:0][soc_bus_pkg::DATA_W-1:0] periph_out_o,

    // sram pins, tristate split into in / out / oe
    input  logic [soc_bus_pkg::DATA_W-1:0]       base_ram_data_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]       ext_ram_data_i,
    output logic [soc_bus_pkg::SRAM_ADDR_W-1:0]  ram_addr_o,
    output logic [soc_bus_pkg::BE_W-1:0]         ram_be_n_o,
    output logic                                 base_ram_ce_n_o,
    output logic                                 ext_ram_ce_n_o,
    output logic                                 ram_oe_n_o,
    output logic                                 ram_we_n_o,
    output logic [soc_bus_pkg::DATA_W-1:0]       ram_data_o,
    output logic                                 ram_data_oe_o
);

    logic [soc_bus_pkg::NUM_PERIPH-1:0]                          bank_we;
    logic [soc_bus_pkg::REG_IDX_W-1:0]                           reg_idx;
    logic [soc_bus_pkg::DATA_W-1:0]                              wr_data;
    logic [soc_bus_pkg::BE_W-1:0]                                wr_be;
    logic                                                        ram_req;
    logic                                                        ram_write;
    logic [soc_bus_pkg::SRAM_ADDR_W:0]                           ram_addr;
    logic [soc_bus_pkg::KIND_W-1:0]                              rd_kind;
    logic [soc_bus_pkg::SLOT_W-1:0]                              rd_slot;
    logic [soc_bus_pkg::NUM_PERIPH-1:0][soc_bus_pkg::DATA_W-1:0] bank_rd_data;
    logic [soc_bus_pkg::DATA_W-1:0]                              ram_rd_data;
    logic                                                        ram_done;

    dbus_decoder u_decoder (
        .m_addr_i    (m_addr_i),
        .m_be_i      (m_be_i),
        .m_read_i    (m_read_i),
        .m_write_i   (m_write_i),
        .m_wrdata_i  (m_wrdata_i),
        .bank_we_o   (bank_we),
        .reg_idx_o   (reg_idx),
        .wr_data_o   (wr_data),
        .wr_be_o     (wr_be),
        .ram_req_o   (ram_req),
        .ram_write_o (ram_write),
        .ram_addr_o  (ram_addr),
        .rd_kind_o   (rd_kind),
        .rd_slot_o   (rd_slot)
    );

    for (genvar i = 0; i < soc_bus_pkg::NUM_PERIPH; i++) begin : g_bank
        reg_bank u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .we_i      (bank_we[i]),
            .reg_idx_i (reg_idx),
            .wr_data_i (wr_data),
            .wr_be_i   (wr_be),
            .pins_i    (periph_in_i[i]),
            .rd_data_o (bank_rd_data[i]),
            .port_o    (periph_out_o[i])
        );
    end

    dbus_rdmux u_rdmux (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_kind_i      (rd_kind),
        .rd_slot_i      (rd_slot),
        .bank_rd_data_i (bank_rd_data),
        .ram_rd_data_i  (ram_rd_data),
        .ram_done_i     (ram_done),
        .m_rddata_o     (m_rddata_o)
    );

    sram_ctrl u_sram_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (ram_req),
        .write_i         (ram_write),
        .addr_i          (ram_addr),
        .be_i            (wr_be),
        .wr_data_i       (wr_data),
        .base_ram_data_i (base_ram_data_i),
        .ext_ram_data_i  (ext_ram_data_i),
        .stall_o         (m_stall_o),  // only ram stalls the master
        .done_o          (ram_done),
        .rd_data_o       (ram_rd_data),
        .ram_addr_o      (ram_addr_o),
        .ram_be_n_o      (ram_be_n_o),
        .base_ram_ce_n_o (base_ram_ce_n_o),
        .ext_ram_ce_n_o  (ext_ram_ce_n_o),
        .ram_oe_n_o      (ram_oe_n_o),
        .ram_we_n_o      (ram_we_n_o),
        .ram_data_o      (ram_data_o),
        .ram_data_oe_o   (ram_data_oe_o)
    );

endmodule

// File: sim/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  logic [soc_bus_pkg::SRAM_ADDR_W-1:0]  addr_i,
    input  logic [soc_bus_pkg::BE_W-1:0]         be_n_i,
    input  logic                                 base_ce_n_i,
    input  logic                                 ext_ce_n_i,
    input  logic                                 oe_n_i,
    input  logic                                 we_n_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]       data_i,
    input  logic                                 data_oe_i,
    output wire  [soc_bus_pkg::DATA_W-1:0]       base_data_o,
    output wire  [soc_bus_pkg::DATA_W-1:0]       ext_data_o
);

    // chip 0 is base, chip 1 is ext
    logic [soc_bus_pkg::DATA_W-1:0]      mem [0:1][0:(1 << soc_bus_pkg::SRAM_ADDR_W)-1];

    logic                                wr_armed = 1'b0;
    logic                                wr_chip;
    logic [soc_bus_pkg::SRAM_ADDR_W-1:0] wr_addr;
    logic [soc_bus_pkg::BE_W-1:0]        wr_be;
    logic [soc_bus_pkg::DATA_W-1:0]      wr_data;

    // shared pads, controller and chip drive the same wire
    assign base_data_o = data_oe_i ? data_i : 'z;
    assign base_data_o = (!base_ce_n_i && !oe_n_i) ? mem[0][addr_i] : 'z;
    assign ext_data_o  = data_oe_i ? data_i : 'z;
    assign ext_data_o  = (!ext_ce_n_i && !oe_n_i) ? mem[1][addr_i] : 'z;

    // follow the bus while the write pulse is low
    always @* begin
        if (!we_n_i && !(base_ce_n_i && ext_ce_n_i)) begin
            wr_armed = 1'b1;
            wr_chip  = !ext_ce_n_i;
            wr_addr  = addr_i;
            wr_be    = ~be_n_i;
            wr_data  = data_i;
        end
    end

    // commit on the trailing edge of we_n
    always @(posedge we_n_i) begin
        if (wr_armed) begin
            for (int b = 0; b < soc_bus_pkg::BE_W; b++) begin
                if (wr_be[b]) begin
                    mem[wr_chip][wr_addr][8*b +: 8] = wr_data[8*b +: 8];
                end
            end
            wr_armed = 1'b0;
        end
    end

endmodule

// File: sim/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

    localparam int          CLK_HALF     = 10;
    localparam int          RESET_CYCLES = 2;
    localparam logic [15:0] LFSR_SEED    = 16'd16;
    localparam logic [1:0]  OP_WR        = 2'd0;
    localparam logic [1:0]  OP_RD        = 2'd1;
    localparam logic [1:0]  OP_PORT      = 2'd2;  // no strobe, check periph_out_o

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
        logic [31:0] exp;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] m_addr_i;
    logic [3:0]  m_be_i;
    logic        m_read_i;
    logic        m_write_i;
    logic [31:0] m_wrdata_i;
    logic [31:0] m_rddata_o;
    logic        m_stall_o;
    logic [soc_bus_pkg::NUM_PERIPH-1:0][31:0] periph_in_i;
    logic [soc_bus_pkg::NUM_PERIPH-1:0][31:0] periph_out_o;
    wire  [31:0] base_ram_data_i;
    wire  [31:0] ext_ram_data_i;
    logic [19:0] ram_addr_o;
    logic [3:0]  ram_be_n_o;
    logic        base_ram_ce_n_o;
    logic        ext_ram_ce_n_o;
    logic        ram_oe_n_o;
    logic        ram_we_n_o;
    logic [31:0] ram_data_o;
    logic        ram_data_oe_o;

    entry_t      stim[$];
    logic [31:0] sb [0:47];  // 0..15 bank registers, 16..47 ram words
    logic [15:0] lfsr = LFSR_SEED;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          cur_idx = -1;
    logic        pend_valid = 1'b0;
    logic [31:0] pend_exp;

    soc_bus_top UUT (.*);

    sram_model u_sram (
        .addr_i      (ram_addr_o),
        .be_n_i      (ram_be_n_o),
        .base_ce_n_i (base_ram_ce_n_o),
        .ext_ce_n_i  (ext_ram_ce_n_o),
        .oe_n_i      (ram_oe_n_o),
        .we_n_i      (ram_we_n_o),
        .data_i      (ram_data_o),
        .data_oe_i   (ram_data_oe_o),
        .base_data_o (base_ram_data_i),
        .ext_data_o  (ext_ram_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            report_fail($sformatf("Timeout: test still running after %0d clock cycles",
                                  cycle_limit));
        end
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
            else report_fail($sformatf("Error: %s = 0x%08h, expected 0x%08h (entry %0d)",
                                       name, got, exp, cur_idx));
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr[0];  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] merge_word(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] pin_word(input int slot);
        return 32'hC0DE_0000 + slot * 32'h0111;
    endfunction

    // junk in the offset bits the decoder ignores
    function automatic logic [31:0] reg_addr(input int slot, input int idx);
        return 32'hBFD0_3C40 | (slot << 8) | (idx << 2);
    endfunction

    function automatic logic [31:0] ram_word_addr(input int chip, input int word);
        return 32'h8000_0000 | (chip << 22) | (word << 2);
    endfunction

    // scoreboard slot, -1 when unmapped
    function automatic int sb_index(input logic [31:0] a);
        if (a[31:28] == soc_bus_pkg::RAM_BASE) begin
            return 16 + 16 * a[22] + a[5:2];  // test words differ in the low nibble
        end
        if (a[31:16] == soc_bus_pkg::PERIPH_BASE) begin
            return 4 * a[9:8] + a[3:2];
        end
        return -1;
    endfunction

    task automatic add_entry(input logic [1:0] op, input logic [31:0] addr, input logic [3:0] be);
        entry_t      e;
        logic [31:0] w;
        int          k;
        k = sb_index(addr);
        w = '0;
        if (op == OP_WR) begin
            random_word(w);
            if (k >= 0 && !(k < 16 && addr[3:2] == 2'd1)) begin
                sb[k] = merge_word(sb[k], w, be);
            end
        end
        e.op   = op;
        e.addr = addr;
        e.be   = be;
        e.data = w;
        if (k < 0) begin
            e.exp = '0;
        end else if (k < 16 && addr[3:2] == 2'd1) begin
            e.exp = pin_word(addr[9:8]);  // register 1 reads the pins
        end else begin
            e.exp = sb[k];
        end
        stim.push_back(e);
    endtask

    task automatic build_table();
        for (int s = 0; s < soc_bus_pkg::NUM_PERIPH; s++) begin
            add_entry(OP_WR, reg_addr(s, 0), 4'hF);
            add_entry(OP_WR, reg_addr(s, 0), 4'b0101 << (s % 2));
            add_entry(OP_RD, reg_addr(s, 0), 4'h0);
            add_entry(OP_PORT, reg_addr(s, 0), 4'h0);
            add_entry(OP_WR, reg_addr(s, 2), 4'hF);
            add_entry(OP_WR, reg_addr(s, 3), 4'hF);
            add_entry(OP_WR, reg_addr(s, 3), 4'b0110);
        end
        for (int s = 0; s < soc_bus_pkg::NUM_PERIPH; s++) begin
            add_entry(OP_RD, reg_addr(s, 2), 4'h0);
            add_entry(OP_RD, reg_addr(3 - s, 3), 4'h0);
        end
        for (int s = 0; s < soc_bus_pkg::NUM_PERIPH; s++) begin
            add_entry(OP_RD, reg_addr(s, 1), 4'h0);
            add_entry(OP_WR, reg_addr(s, 1), 4'hF);
            add_entry(OP_RD, reg_addr(s, 1), 4'h0);
        end
        // same word in both chips
        add_entry(OP_WR, ram_word_addr(0, 'h00101), 4'hF);
        add_entry(OP_WR, ram_word_addr(1, 'h00101), 4'hF);
        add_entry(OP_RD, ram_word_addr(0, 'h00101), 4'h0);
        add_entry(OP_RD, ram_word_addr(1, 'h00101), 4'h0);
        add_entry(OP_WR, ram_word_addr(0, 'h00101), 4'b0011);
        add_entry(OP_RD, ram_word_addr(0, 'h00101), 4'h0);
        add_entry(OP_WR, ram_word_addr(1, 'h00101), 4'b1000);
        add_entry(OP_RD, ram_word_addr(1, 'h00101), 4'h0);
        add_entry(OP_WR, ram_word_addr(0, 'hFFFFF), 4'hF);
        add_entry(OP_WR, ram_word_addr(1, 'h2A5A6), 4'hF);
        add_entry(OP_WR, ram_word_addr(1, 'h2A5A6), 4'b0100);
        add_entry(OP_RD, ram_word_addr(0, 'hFFFFF), 4'h0);
        add_entry(OP_RD, ram_word_addr(1, 'h2A5A6), 4'h0);
        // unmapped, the writes alias ram word 0x101 and bank 1 register 0
        add_entry(OP_RD, 32'h0000_0100, 4'h0);
        add_entry(OP_RD, 32'hBFD1_0000, 4'h0);
        add_entry(OP_WR, 32'h9000_0404, 4'hF);
        add_entry(OP_WR, 32'hBFD1_0100, 4'hF);
        add_entry(OP_WR, 32'h0040_0404, 4'hF);
        add_entry(OP_RD, reg_addr(1, 0), 4'h0);
        add_entry(OP_RD, ram_word_addr(0, 'h00101), 4'h0);
        add_entry(OP_RD, ram_word_addr(1, 'h00101), 4'h0);
        add_entry(OP_PORT, reg_addr(1, 0), 4'h0);  // also drains the last read
    endtask

    // sram pins while the strobes are active
    task automatic check_ram_pins(input entry_t e);
        logic wr;
        wr = (e.op == OP_WR);
        expect_equal("ram_addr_o", ram_addr_o, e.addr[21:2]);
        expect_equal("ram_be_n_o", ram_be_n_o, 4'(~e.be));
        expect_equal("{base_ram_ce_n_o, ext_ram_ce_n_o}",
                     {base_ram_ce_n_o, ext_ram_ce_n_o}, e.addr[22] ? 2'b10 : 2'b01);
        expect_equal("{ram_oe_n_o, ram_we_n_o}", {ram_oe_n_o, ram_we_n_o}, {wr, !wr});
        expect_equal("ram_data_oe_o", ram_data_oe_o, wr);
        if (wr) begin
            expect_equal("ram_data_o", ram_data_o, e.data);
        end
    endtask

    task automatic apply_entry(input int idx);
        entry_t e;
        int     stalls;
        logic   ram_hit;
        e       = stim[idx];
        cur_idx = idx;
        @(posedge clk);
        #2;
        m_addr_i   = e.addr;
        m_be_i     = e.be;
        m_wrdata_i = e.data;
        m_read_i   = (e.op == OP_RD);
        m_write_i  = (e.op == OP_WR);
        @(negedge clk);
        if (pend_valid) begin  // read of the previous entry lands now
            expect_equal("m_rddata_o", m_rddata_o, pend_exp);
            pend_valid = 1'b0;
        end
        if (e.op == OP_PORT) begin
            expect_equal("periph_out_o", periph_out_o[e.addr[9:8]], e.exp);
        end
        stalls = 0;
        while (m_stall_o) begin
            check_ram_pins(e);
            stalls++;
            @(negedge clk);
        end
        ram_hit = (e.addr[31:28] == soc_bus_pkg::RAM_BASE) && (e.op != OP_PORT);
        expect_equal("m_stall_o cycles", stalls, ram_hit ? soc_bus_pkg::RAM_WAIT_CYCLES : 0);
        if (e.op == OP_RD && ram_hit) begin
            expect_equal("m_rddata_o", m_rddata_o, e.exp);
        end else if (e.op == OP_RD) begin
            pend_valid = 1'b1;
            pend_exp   = e.exp;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        m_addr_i   = '0;
        m_be_i     = '0;
        m_read_i   = 1'b0;
        m_write_i  = 1'b0;
        m_wrdata_i = '0;
        for (int s = 0; s < soc_bus_pkg::NUM_PERIPH; s++) begin
            periph_in_i[s] = pin_word(s);
        end
        for (int k = 0; k < 48; k++) begin
            sb[k] = '0;
        end
        build_table();
        cycle_limit = stim.size() * 4 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        expect_equal("m_stall_o", m_stall_o, 1'b0);
        expect_equal("{base_ram_ce_n_o, ext_ram_ce_n_o, ram_oe_n_o, ram_we_n_o}",
                     {base_ram_ce_n_o, ext_ram_ce_n_o, ram_oe_n_o, ram_we_n_o}, 4'hF);
        expect_equal("ram_data_oe_o", ram_data_oe_o, 1'b0);
        for (int s = 0; s < soc_bus_pkg::NUM_PERIPH; s++) begin
            expect_equal("periph_out_o", periph_out_o[s], '0);
        end
        for (int i = 0; i < stim.size(); i++) begin
            apply_entry(i);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: all.f
hdl/soc_bus_pkg.sv
hdl/dbus_decoder.sv
hdl/reg_bank.sv
hdl/dbus_rdmux.sv
hdl/sram_ctrl.sv
hdl/soc_bus_top.sv
sim/sram_model.sv
sim/tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - hdl/soc_bus_pkg.sv
  - hdl/dbus_decoder.sv
  - hdl/reg_bank.sv
  - hdl/dbus_rdmux.sv
  - hdl/sram_ctrl.sv
  - hdl/soc_bus_top.sv
  - target: simulation
    files:
      - sim/sram_model.sv
      - sim/tb_soc_bus.sv
